// File: source/uart_io_cfg.svh
// UART peripheral configuration macros for register map, bit timing and queue size
`ifndef UART_IO_CFG_SVH
`define UART_IO_CFG_SVH

// ------------------------------
// Register window
// ------------------------------

// Base byte address of the window
`define UART_IO_BASE_ADDR   32'h8000_0000

// Byte offsets of the three word registers
`define UART_IO_STATUS_OFS  32'h0000_0000
`define UART_IO_RXDATA_OFS  32'h0000_0004
`define UART_IO_TXDATA_OFS  32'h0000_0008

// ------------------------------
// Serial timing and queues
// ------------------------------

`define UART_CLKS_PER_BIT   8
`define UART_FIFO_DEPTH     4

`endif

// File: source/uart_io_pkg.sv
// UART peripheral shared types and status register bit positions
`default_nettype none

package uart_io_pkg;

    // One received frame as stored in the receive queue
    typedef struct packed
    {
        logic [7:0] data;
        logic       frame_error;
    } rx_entry_t;

    // Transmit queue not full
    localparam int status_tx_ready_bit = 0;

    // Receive queue not empty
    localparam int status_rx_valid_bit = 1;

    // Frame error flag of the oldest received entry
    localparam int status_rx_error_bit = 2;

endpackage

`default_nettype wire

// File: source/byte_fifo.sv
// Synchronous FIFO with valid/ready output side and a configurable payload type
`default_nettype none

module byte_fifo #(
    parameter type item_t = logic [7:0],
    parameter int  depth  = 4
) (
    input  wire   clock,
    input  wire   rst_n,
    input  wire   push,
    input  item_t push_data,
    input  wire   out_ready,
    output logic  full,
    output logic  out_valid,
    output item_t out_data
);

    // Depth is a power of two, pointers carry one extra wrap bit
    localparam int aw = $clog2(depth);

    item_t         mem [depth];
    logic [aw:0]   wr_ptr;
    logic [aw:0]   rd_ptr;
    logic          do_push;
    logic          do_pop;

    // Full when indices match but wrap bits differ
    assign full      = (wr_ptr[aw] != rd_ptr[aw]) && (wr_ptr[aw-1:0] == rd_ptr[aw-1:0]);
    assign out_valid = (wr_ptr != rd_ptr);
    assign out_data  = mem[rd_ptr[aw-1:0]];

    // A push into a full queue is dropped
    assign do_push = push && !full;
    assign do_pop  = out_ready && out_valid;

    always_ff @(posedge clock or negedge rst_n)
    begin
        if (!rst_n)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end
        else
        begin
            if (do_push)
                wr_ptr <= wr_ptr + 1'b1;
            if (do_pop)
                rd_ptr <= rd_ptr + 1'b1;
        end
    end

    // Storage array
    always_ff @(posedge clock)
    begin
        if (do_push)
            mem[wr_ptr[aw-1:0]] <= push_data;
    end

endmodule

`default_nettype wire

// File: source/uart_tx.sv
// UART transmitter serializing bytes as 8N1 frames, least significant bit first
`default_nettype none

module uart_tx #(
    parameter int clks_per_bit = 8
) (
    input  wire       clock,
    input  wire       rst_n,
    input  wire       in_valid,
    input  wire [7:0] in_data,
    output logic      in_ready,
    output logic      sout
);

    localparam int            cw       = (clks_per_bit > 1) ? $clog2(clks_per_bit) : 1;
    localparam logic [cw-1:0] baud_end = cw'(clks_per_bit - 1);

    logic          busy;
    logic [cw-1:0] baud_cnt;
    logic [3:0]    bit_idx;
    logic [8:0]    frame_q;
    logic          bit_end;

    assign in_ready = !busy;
    assign bit_end  = busy && (baud_cnt == baud_end);

    // ------------------------------
    // Bit sequencing
    // ------------------------------
    always_ff @(posedge clock or negedge rst_n)
    begin
        if (!rst_n)
        begin
            busy     <= 1'b0;
            sout     <= 1'b1;
            baud_cnt <= '0;
            bit_idx  <= '0;
        end
        else if (!busy)
        begin
            // Start bit goes out right after the transfer
            if (in_valid)
            begin
                busy     <= 1'b1;
                sout     <= 1'b0;
                baud_cnt <= '0;
                bit_idx  <= '0;
            end
        end
        else if (bit_end)
        begin
            baud_cnt <= '0;
            if (bit_idx == 4'd9)
            begin
                busy <= 1'b0;
                sout <= 1'b1;
            end
            else
            begin
                sout    <= frame_q[0];
                bit_idx <= bit_idx + 1'b1;
            end
        end
        else
            baud_cnt <= baud_cnt + 1'b1;
    end

    // Data bits followed by the stop bit, shifted out from bit 0
    always_ff @(posedge clock)
    begin
        if (in_valid && !busy)
            frame_q <= {1'b1, in_data};
        else if (bit_end)
            frame_q <= {1'b1, frame_q[8:1]};
    end

endmodule

`default_nettype wire

// File: source/uart_rx.sv
// UART receiver with input synchronizer, mid-bit sampling and stop bit framing check
`default_nettype none

module uart_rx
    import uart_io_pkg::*;
#(
    parameter int clks_per_bit = 8
) (
    input  wire       clock,
    input  wire       rst_n,
    input  wire       sin,
    output logic      out_valid,
    output rx_entry_t out_data
);

    localparam int            cw       = (clks_per_bit > 1) ? $clog2(clks_per_bit) : 1;
    localparam logic [cw-1:0] baud_end = cw'(clks_per_bit - 1);
    localparam logic [cw-1:0] half_end = cw'(clks_per_bit / 2 - 1);

    typedef enum logic [1:0]
    {
        RX_IDLE,
        RX_START,
        RX_DATA,
        RX_STOP
    } rx_state_t;

    rx_state_t     state;
    logic [1:0]    sync_q;
    logic          sin_s;
    logic          sin_d;
    logic [cw-1:0] baud_cnt;
    logic [2:0]    bit_idx;
    logic [7:0]    shift_q;
    logic          err_q;

    assign sin_s    = sync_q[1];
    assign out_data = '{data: shift_q, frame_error: err_q};

    // Two-stage synchronizer plus one delay stage for edge detect
    always_ff @(posedge clock or negedge rst_n)
    begin
        if (!rst_n)
        begin
            sync_q <= 2'b11;
            sin_d  <= 1'b1;
        end
        else
        begin
            sync_q <= {sync_q[0], sin};
            sin_d  <= sin_s;
        end
    end

    // ------------------------------
    // Frame FSM
    // ------------------------------
    always_ff @(posedge clock or negedge rst_n)
    begin
        if (!rst_n)
        begin
            state     <= RX_IDLE;
            baud_cnt  <= '0;
            bit_idx   <= '0;
            out_valid <= 1'b0;
        end
        else
        begin
            out_valid <= 1'b0;
            case (state)
                RX_IDLE:
                begin
                    baud_cnt <= '0;
                    if (sin_d && !sin_s)
                        state <= RX_START;
                end
                RX_START:
                begin
                    if (baud_cnt == half_end)
                    begin
                        baud_cnt <= '0;
                        bit_idx  <= '0;
                        // High again at mid-bit means a glitch
                        state    <= sin_s ? RX_IDLE : RX_DATA;
                    end
                    else
                        baud_cnt <= baud_cnt + 1'b1;
                end
                RX_DATA:
                begin
                    if (baud_cnt == baud_end)
                    begin
                        baud_cnt <= '0;
                        bit_idx  <= bit_idx + 1'b1;
                        if (bit_idx == 3'd7)
                            state <= RX_STOP;
                    end
                    else
                        baud_cnt <= baud_cnt + 1'b1;
                end
                default:
                begin
                    if (baud_cnt == baud_end)
                    begin
                        baud_cnt  <= '0;
                        state     <= RX_IDLE;
                        out_valid <= 1'b1;
                    end
                    else
                        baud_cnt <= baud_cnt + 1'b1;
                end
            endcase
        end
    end

    // Sampled data bits and stop bit check
    always_ff @(posedge clock)
    begin
        if (state == RX_DATA && baud_cnt == baud_end)
            shift_q <= {sin_s, shift_q[7:1]};
        if (state == RX_STOP && baud_cnt == baud_end)
            err_q <= !sin_s;
    end

endmodule

`default_nettype wire

// File: source/uart_io_regs.sv
// UART bus register block decoding status, receive and transmit data registers
`default_nettype none
`include "uart_io_cfg.svh"

module uart_io_regs
    import uart_io_pkg::*;
(
    input  wire        clock,
    input  wire        rst_n,
    input  wire [31:0] addr,
    input  wire        wr_en,
    input  wire        rd_en,
    input  wire [31:0] wr_data,
    input  wire        tx_full,
    input  wire        rx_valid,
    input  rx_entry_t  rx_entry,
    output logic [31:0] rd_data,
    output logic       tx_push,
    output logic [7:0] tx_byte,
    output logic       rx_pop
);

    localparam logic [31:0] status_addr = `UART_IO_BASE_ADDR + `UART_IO_STATUS_OFS;
    localparam logic [31:0] rxdata_addr = `UART_IO_BASE_ADDR + `UART_IO_RXDATA_OFS;
    localparam logic [31:0] txdata_addr = `UART_IO_BASE_ADDR + `UART_IO_TXDATA_OFS;

    logic        sel_status;
    logic        sel_rxdata;
    logic        sel_txdata;
    logic [31:0] status_word;
    logic        tx_pend_q;

    assign sel_status = (addr == status_addr);
    assign sel_rxdata = (addr == rxdata_addr);
    assign sel_txdata = (addr == txdata_addr);

    // ------------------------------
    // Read side
    // ------------------------------
    always_comb
    begin
        status_word                      = '0;
        status_word[status_tx_ready_bit] = !tx_full;
        status_word[status_rx_valid_bit] = rx_valid;
        status_word[status_rx_error_bit] = rx_valid && rx_entry.frame_error;
    end

    // Unmapped or idle reads return zero
    always_comb
    begin
        rd_data = '0;
        if (rd_en)
        begin
            if (sel_status)
                rd_data = status_word;
            else if (sel_rxdata && rx_valid)
                rd_data = {24'h0, rx_entry.data};
        end
    end

    // Head entry leaves the queue at the end of the read cycle
    assign rx_pop = rd_en && sel_rxdata && rx_valid;

    // ------------------------------
    // Write side
    // ------------------------------

    // Write is staged one cycle, then pushed against the current full flag
    always_ff @(posedge clock or negedge rst_n)
    begin
        if (!rst_n)
            tx_pend_q <= 1'b0;
        else
            tx_pend_q <= wr_en && sel_txdata;
    end

    always_ff @(posedge clock)
    begin
        if (wr_en && sel_txdata)
            tx_byte <= wr_data[7:0];
    end

    // Dropped when the transmit queue is full
    assign tx_push = tx_pend_q && !tx_full;

endmodule

`default_nettype wire

// File: source/uart_io_top.sv
// UART peripheral top level joining the register block, both queues and serial engines
`default_nettype none
`include "uart_io_cfg.svh"

module uart_io_top
    import uart_io_pkg::*;
(
    input  wire         clock,
    input  wire         rst_n,
    input  wire  [31:0] addr,
    input  wire         wr_en,
    input  wire         rd_en,
    input  wire  [31:0] wr_data,
    input  wire         sin,
    output logic [31:0] rd_data,
    output logic        sout
);

    // Transmit path
    logic       tx_push;
    logic [7:0] tx_byte;
    logic       tx_full;
    logic       tx_valid;
    logic [7:0] tx_data;
    logic       tx_ready;

    // Receive path
    logic       rx_frame_valid;
    rx_entry_t  rx_frame;
    logic       rx_valid;
    rx_entry_t  rx_entry;
    logic       rx_pop;

    uart_io_regs u_regs (
        .clock    (clock),
        .rst_n    (rst_n),
        .addr     (addr),
        .wr_en    (wr_en),
        .rd_en    (rd_en),
        .wr_data  (wr_data),
        .tx_full  (tx_full),
        .rx_valid (rx_valid),
        .rx_entry (rx_entry),
        .rd_data  (rd_data),
        .tx_push  (tx_push),
        .tx_byte  (tx_byte),
        .rx_pop   (rx_pop)
    );

    byte_fifo #(.item_t(logic [7:0]), .depth(`UART_FIFO_DEPTH)) u_tx_fifo (
        .clock     (clock),
        .rst_n     (rst_n),
        .push      (tx_push),
        .push_data (tx_byte),
        .out_ready (tx_ready),
        .full      (tx_full),
        .out_valid (tx_valid),
        .out_data  (tx_data)
    );

    uart_tx #(.clks_per_bit(`UART_CLKS_PER_BIT)) u_tx (
        .clock    (clock),
        .rst_n    (rst_n),
        .in_valid (tx_valid),
        .in_data  (tx_data),
        .in_ready (tx_ready),
        .sout     (sout)
    );

    // Receive queue drops frames on its own when full
    byte_fifo #(.item_t(rx_entry_t), .depth(`UART_FIFO_DEPTH)) u_rx_fifo (
        .clock     (clock),
        .rst_n     (rst_n),
        .push      (rx_frame_valid),
        .push_data (rx_frame),
        .out_ready (rx_pop),
        .full      (),
        .out_valid (rx_valid),
        .out_data  (rx_entry)
    );

    uart_rx #(.clks_per_bit(`UART_CLKS_PER_BIT)) u_rx (
        .clock     (clock),
        .rst_n     (rst_n),
        .sin       (sin),
        .out_valid (rx_frame_valid),
        .out_data  (rx_frame)
    );

endmodule

`default_nettype wire

// File: testbench/uart_io_tb.sv
// Testbench for the UART peripheral covering register access, serial transmit and receive
`default_nettype none
`include "uart_io_cfg.svh"

module uart_io_tb
    import uart_io_pkg::*;
();

    localparam int          cpb         = `UART_CLKS_PER_BIT;
    localparam int          depth       = `UART_FIFO_DEPTH;
    localparam logic [31:0] status_addr = `UART_IO_BASE_ADDR + `UART_IO_STATUS_OFS;
    localparam logic [31:0] rxdata_addr = `UART_IO_BASE_ADDR + `UART_IO_RXDATA_OFS;
    localparam logic [31:0] txdata_addr = `UART_IO_BASE_ADDR + `UART_IO_TXDATA_OFS;
    localparam int          frame_limit = (depth + 2) * 12 * cpb + 100;

    logic        clock;
    logic        rst_n;
    logic [31:0] addr;
    logic        wr_en;
    logic        rd_en;
    logic [31:0] wr_data;
    logic        sin;
    logic [31:0] rd_data;
    logic        sout;

    integer      seed;
    int          errors;
    int          timeouts;
    int          mon_errors;
    int          cmp_errors;
    int          tx_checked;
    int          tx_model_count;
    logic [8:0]  mon_q[$];
    logic [7:0]  tx_exp_q[$];
    logic [8:0]  rx_model[$];

    // Serial monitor state
    logic        mon_busy;
    int          mon_cnt;
    int          bit_no;
    logic [8:0]  mon_frame;
    logic [8:0]  got_frame;
    logic [8:0]  exp_frame;

    uart_io_top uut (
        .clock   (clock),
        .rst_n   (rst_n),
        .addr    (addr),
        .wr_en   (wr_en),
        .rd_en   (rd_en),
        .wr_data (wr_data),
        .sin     (sin),
        .rd_data (rd_data),
        .sout    (sout)
    );

    always #4 clock = ~clock;

    // ------------------------------
    // Reference model
    // ------------------------------
    function automatic logic [31:0] expected_status(input int tx_count, input int rx_count,
                                                    input logic head_err);
        logic [31:0] s;
        s                      = '0;
        s[status_tx_ready_bit] = (tx_count < depth);
        s[status_rx_valid_bit] = (rx_count > 0);
        s[status_rx_error_bit] = (rx_count > 0) && head_err;
        return s;
    endfunction

    // Entry is {frame_error, byte}
    function automatic logic [31:0] expected_rx_word(input logic [8:0] entry);
        return {24'h0, entry[7:0]};
    endfunction

    // Decoded sout frame is {stop bit, byte}
    function automatic logic [8:0] expected_frame(input logic [7:0] b);
        return {1'b1, b};
    endfunction

    // ------------------------------
    // Bus and serial tasks
    // ------------------------------
    task automatic bus_write(input logic [31:0] a, input logic [31:0] d);
        addr    = a;
        wr_data = d;
        wr_en   = 1'b1;
        @(posedge clock);
        #1;
        wr_en = 1'b0;
    endtask

    task automatic bus_read(input logic [31:0] a, output logic [31:0] d);
        addr  = a;
        rd_en = 1'b1;
        @(negedge clock);
        d = rd_data;
        @(posedge clock);
        #1;
        rd_en = 1'b0;
    endtask

    task automatic check_status(input string what);
        logic [31:0] got;
        logic [31:0] exp;
        logic        head_err;
        head_err = (rx_model.size() > 0) ? rx_model[0][8] : 1'b0;
        exp      = expected_status(tx_model_count, rx_model.size(), head_err);
        bus_read(status_addr, got);
        assert (got == exp)
        else
        begin
            errors++;
            $display("error at %0t: %s status 0x%h, expected 0x%h", $time, what, got, exp);
        end
    endtask

    task automatic read_rx_check();
        logic [31:0] got;
        logic [31:0] exp;
        exp = 32'h0;
        if (rx_model.size() > 0)
            exp = expected_rx_word(rx_model.pop_front());
        bus_read(rxdata_addr, got);
        assert (got == exp)
        else
        begin
            errors++;
            $display("error at %0t: receive data 0x%h, expected 0x%h", $time, got, exp);
        end
    endtask

    task automatic send_frame(input logic [7:0] b, input logic stop_bit);
        logic [9:0] bits;
        int         i;
        bits = {stop_bit, b, 1'b0};
        for (i = 0; i < 10; i++)
        begin
            sin = bits[i];
            repeat (cpb) @(posedge clock);
            #1;
        end
        sin = 1'b1;
        // Idle line after a low stop bit so the next start edge is seen
        if (!stop_bit)
        begin
            repeat (cpb) @(posedge clock);
            #1;
        end
        // A full receive queue drops the frame
        if (rx_model.size() < depth)
            rx_model.push_back({~stop_bit, b});
    endtask

    task automatic wait_rx_valid();
        logic [31:0] s;
        int          tries;
        s     = '0;
        tries = 0;
        while (!s[status_rx_valid_bit] && tries < 4 * cpb)
        begin
            bus_read(status_addr, s);
            tries++;
        end
        if (!s[status_rx_valid_bit])
        begin
            timeouts++;
            $display("timeout at %0t: receive queue never reported valid data", $time);
        end
    endtask

    task automatic wait_tx_done();
        int cycles;
        cycles = 0;
        while ((tx_checked < tx_exp_q.size() || mon_busy) && cycles < frame_limit)
        begin
            @(posedge clock);
            #1;
            cycles++;
        end
        if (tx_checked < tx_exp_q.size() || mon_busy)
        begin
            timeouts++;
            $display("timeout at %0t: written bytes did not all appear on sout", $time);
        end
    endtask

    // ------------------------------
    // Monitor and comparison
    // ------------------------------

    // Samples sout at mid-bit, counting from the first low half cycle
    always @(negedge clock)
    begin
        if (!rst_n)
        begin
            mon_busy = 1'b0;
            mon_cnt  = 0;
        end
        else if (!mon_busy)
        begin
            if (sout == 1'b0)
            begin
                mon_busy = 1'b1;
                mon_cnt  = 0;
            end
        end
        else
        begin
            mon_cnt++;
            if (mon_cnt % cpb == cpb / 2)
            begin
                bit_no = mon_cnt / cpb;
                if (bit_no == 0)
                begin
                    assert (sout == 1'b0)
                    else
                    begin
                        mon_errors++;
                        $display("error at %0t: start bit high at mid-bit", $time);
                    end
                end
                else if (bit_no <= 8)
                    mon_frame[bit_no - 1] = sout;
                else
                begin
                    mon_frame[8] = sout;
                    mon_q.push_back(mon_frame);
                    mon_busy = 1'b0;
                end
            end
        end
    end

    // Frames without an expected byte compare against zero and fail
    always @(posedge clock)
    begin
        if (tx_checked < mon_q.size())
        begin
            got_frame = mon_q[tx_checked];
            exp_frame = 9'h000;
            if (tx_checked < tx_exp_q.size())
                exp_frame = expected_frame(tx_exp_q[tx_checked]);
            assert (got_frame == exp_frame)
            else
            begin
                cmp_errors++;
                $display("error at %0t: sout frame %0d was 0x%h, expected 0x%h",
                         $time, tx_checked, got_frame, exp_frame);
            end
            tx_checked++;
        end
    end

    // ------------------------------
    // Test sequence
    // ------------------------------
    initial
    begin
        logic [31:0] r;
        logic [31:0] word;
        int          n;
        seed           = 32'hc336;
        errors         = 0;
        timeouts       = 0;
        mon_errors     = 0;
        cmp_errors     = 0;
        tx_checked     = 0;
        tx_model_count = 0;
        clock          = 1'b0;
        rst_n          = 1'b0;
        addr           = '0;
        wr_en          = 1'b0;
        rd_en          = 1'b0;
        wr_data        = '0;
        sin            = 1'b1;
        repeat (3) @(posedge clock);
        #1;
        rst_n = 1'b1;

        // Reset state
        check_status("reset");
        bus_read(rxdata_addr, word);
        assert (word == 32'h0)
        else
        begin
            errors++;
            $display("error at %0t: receive data after reset 0x%h", $time, word);
        end
        for (n = 0; n < 4 * cpb; n++)
        begin
            assert (sout == 1'b1)
            else
            begin
                errors++;
                $display("error at %0t: sout low while idle", $time);
            end
            @(posedge clock);
            #1;
        end

        // Transmit random bytes
        for (n = 0; n < depth; n++)
        begin
            r = $random(seed);
            bus_write(txdata_addr, r);
            tx_exp_q.push_back(r[7:0]);
        end
        wait_tx_done();
        check_status("after transmit");

        // Receive random frames
        for (n = 0; n < 3; n++)
        begin
            r = $random(seed);
            send_frame(r[7:0], 1'b1);
            wait_rx_valid();
            check_status("receive");
        end
        for (n = 0; n < 3; n++)
            read_rx_check();
        check_status("after receive");

        // Framing error followed by a good frame
        r = $random(seed);
        send_frame(r[7:0], 1'b0);
        r = $random(seed);
        send_frame(r[7:0], 1'b1);
        wait_rx_valid();
        check_status("framing error at head");
        read_rx_check();
        check_status("good frame at head");
        read_rx_check();
        check_status("after framing error");

        // Transmit overflow, the last write is dropped
        for (n = 0; n < depth + 2; n++)
        begin
            r = $random(seed);
            bus_write(txdata_addr, r);
            if (n < depth + 1)
                tx_exp_q.push_back(r[7:0]);
        end
        tx_model_count = depth;
        check_status("transmit queue full");
        wait_tx_done();
        tx_model_count = 0;
        repeat (20 * cpb) @(posedge clock);
        #1;
        assert (tx_checked == 2 * depth + 1)
        else
        begin
            errors++;
            $display("error at %0t: %0d frames on sout, expected %0d",
                     $time, tx_checked, 2 * depth + 1);
        end
        check_status("after transmit overflow");

        // Receive overflow, only the first entries are kept
        for (n = 0; n < depth + 2; n++)
        begin
            r = $random(seed);
            send_frame(r[7:0], 1'b1);
        end
        wait_rx_valid();
        check_status("receive queue full");
        for (n = 0; n < depth; n++)
            read_rx_check();
        check_status("after receive overflow");

        errors = errors + mon_errors + cmp_errors;
        $display("errors: %0d, timeouts: %0d", errors, timeouts);
        if (errors == 0 && timeouts == 0)
            $display("Result: PASSED");
        else
            $display("Result: FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// File: uart_io_top.f
+incdir+source
source/uart_io_pkg.sv
source/byte_fifo.sv
source/uart_tx.sv
source/uart_rx.sv
source/uart_io_regs.sv
source/uart_io_top.sv
testbench/uart_io_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the UART peripheral testbench with Verilator
set -e

cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing --assert \
    -f uart_io_top.f \
    --top-module uart_io_tb \
    -o uart_io_sim

./obj_dir/uart_io_sim > "$LOG" 2>&1 || { cat "$LOG"; exit 1; }
cat "$LOG"

if grep -q "Result: FAILED" "$LOG"; then
    echo "Simulation reported a failure"
    exit 1
fi

echo "Simulation finished without failure"
exit 0
